// File: apb_data_mem.sv
`timescale 1ns/1ps
`include "rca_consts.svh"

module apb_data_mem (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [`XLEN-1:0] paddr,
    input  logic [`XLEN-1:0] pwdata,
    output logic [`XLEN-1:0] prdata,
    output logic             pready
);
    localparam int IDX_W = $clog2(`MEM_WORDS);

    logic [`XLEN-1:0] mem [`MEM_WORDS];
    logic             wait_cnt;
    logic             access;
    logic [IDX_W-1:0] idx;

    assign access = psel && penable;
    // Byte address in, word index out
    assign idx    = paddr[IDX_W+1:2];

    // Ready only in the second access cycle
    assign pready = access && wait_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= 1'b0;
        end else if (access) begin
            wait_cnt <= !wait_cnt;
        end
    end

    always_ff @(posedge clk) begin
        // Read data fetched during the wait cycle
        if (access && !wait_cnt) begin
            prdata <= mem[idx];
        end
        if (pready && pwrite) begin
            mem[idx] <= pwdata;
        end
    end

endmodule

// File: mem_arbiter.sv
`timescale 1ns/1ps
`include "rca_consts.svh"

module mem_arbiter (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             host_req,
    input  rca_pkg::mem_op_e host_op,
    input  logic [`XLEN-1:0] host_addr,
    input  logic [`XLEN-1:0] host_wdata,
    output logic             host_done,
    output logic [`XLEN-1:0] host_rdata,
    input  logic             lsq_req,
    input  rca_pkg::mem_op_e lsq_op,
    input  logic [`XLEN-1:0] lsq_addr,
    input  logic [`XLEN-1:0] lsq_wdata,
    input  logic             lsq_lock,
    output logic             lsq_done,
    output logic [`XLEN-1:0] lsq_rdata,
    output logic             psel,
    output logic             penable,
    output logic             pwrite,
    output logic [`XLEN-1:0] paddr,
    output logic [`XLEN-1:0] pwdata,
    input  logic [`XLEN-1:0] prdata,
    input  logic             pready
);
    rca_pkg::arb_state_e state;
    logic                owner_lsq;
    logic                grant_lsq;
    logic                grant_host;
    logic                complete;

    // The lock alone decides which master may start
    assign grant_lsq  = lsq_lock && lsq_req;
    assign grant_host = !lsq_lock && host_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= rca_pkg::ARB_IDLE;
            owner_lsq <= 1'b0;
        end else begin
            case (state)
                rca_pkg::ARB_IDLE: begin
                    if (grant_lsq || grant_host) begin
                        state     <= rca_pkg::ARB_SETUP;
                        owner_lsq <= grant_lsq;
                    end
                end
                rca_pkg::ARB_SETUP:  state <= rca_pkg::ARB_ACCESS;
                rca_pkg::ARB_ACCESS: if (pready) state <= rca_pkg::ARB_IDLE;
                default:             state <= rca_pkg::ARB_IDLE;
            endcase
        end
    end

    // Transfer fields frozen at grant, stable for the whole APB transfer
    always_ff @(posedge clk) begin
        if (state == rca_pkg::ARB_IDLE) begin
            if (grant_lsq) begin
                pwrite <= (lsq_op == rca_pkg::OP_STORE);
                paddr  <= lsq_addr;
                pwdata <= lsq_wdata;
            end else if (grant_host) begin
                pwrite <= (host_op == rca_pkg::OP_STORE);
                paddr  <= host_addr;
                pwdata <= host_wdata;
            end
        end
    end

    assign psel     = (state != rca_pkg::ARB_IDLE);
    assign penable  = (state == rca_pkg::ARB_ACCESS);
    assign complete = penable && pready;

    assign host_done  = complete && !owner_lsq;
    assign lsq_done   = complete && owner_lsq;
    assign host_rdata = prdata;
    assign lsq_rdata  = prdata;

endmodule

// File: project.f
+incdir+.
rca_pkg.sv
sync_fifo.sv
rca_lsq.sv
mem_arbiter.sv
apb_data_mem.sv
rca_mem_subsys.sv
rca_mem_props.sv
rca_mem_checker.sv
tb_rca_mem.sv

// File: rca_consts.svh
`ifndef RCA_CONSTS_SVH
`define RCA_CONSTS_SVH

// Data and address width
`define XLEN 32

// Rows of the compute grid, one request slot each
`define GRID_ROWS 4

// Packets the load/store queue can buffer
`define PKT_DEPTH 4

// Data memory depth in words
`define MEM_WORDS 256

`endif

// File: rca_lsq.sv
`timescale 1ns/1ps
`include "rca_consts.svh"

module rca_lsq (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`GRID_ROWS-1:0] row_valid,
    input  rca_pkg::mem_op_e      row_op [`GRID_ROWS],
    input  logic [`XLEN-1:0]      row_addr [`GRID_ROWS],
    input  logic [`XLEN-1:0]      row_wdata [`GRID_ROWS],
    input  logic                  rca_busy,
    output logic                  lsq_full,
    output logic [`GRID_ROWS-1:0] row_load_done,
    output logic [`XLEN-1:0]      row_load_data [`GRID_ROWS],
    output logic                  lsq_req,
    output rca_pkg::mem_op_e      lsq_op,
    output logic [`XLEN-1:0]      lsq_addr,
    output logic [`XLEN-1:0]      lsq_wdata,
    output logic                  lsq_lock,
    input  logic                  lsq_done,
    input  logic [`XLEN-1:0]      lsq_rdata
);
    localparam int ROW_W   = $clog2(`GRID_ROWS);
    // Per row slot: valid, op, address, write data
    localparam int ENTRY_W = 2 + 2 * `XLEN;
    localparam int PKT_W   = `GRID_ROWS * ENTRY_W;

    logic [PKT_W-1:0]      pkt_in;
    logic [PKT_W-1:0]      pkt_head;
    logic                  push;
    logic                  pop;
    logic                  fifo_valid;
    logic [`GRID_ROWS-1:0] head_valid;
    rca_pkg::mem_op_e      head_op [`GRID_ROWS];
    logic [`XLEN-1:0]      head_addr [`GRID_ROWS];
    logic [`XLEN-1:0]      head_wdata [`GRID_ROWS];
    logic [`GRID_ROWS-1:0] completed;
    logic [`GRID_ROWS-1:0] pending;
    logic [`GRID_ROWS-1:0] row_onehot;
    logic [ROW_W-1:0]      next_row;
    logic                  next_found;
    logic                  load_pending;
    logic [ROW_W-1:0]      load_row;
    logic [`XLEN-1:0]      load_data;

    // Capture every offering row of this cycle as one packet
    always_comb begin
        for (int r = 0; r < `GRID_ROWS; r++) begin
            pkt_in[r*ENTRY_W +: ENTRY_W] = {row_valid[r], row_op[r], row_addr[r], row_wdata[r]};
        end
    end

    assign push = (|row_valid) && !lsq_full;

    sync_fifo #(
        .WIDTH(PKT_W),
        .DEPTH(`PKT_DEPTH)
    ) u_pkt_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .pop      (pop),
        .data_in  (pkt_in),
        .data_out (pkt_head),
        .valid    (fifo_valid),
        .full     (lsq_full)
    );

    always_comb begin
        for (int r = 0; r < `GRID_ROWS; r++) begin
            head_valid[r] = pkt_head[r*ENTRY_W + ENTRY_W - 1];
            head_op[r]    = rca_pkg::mem_op_e'(pkt_head[r*ENTRY_W + ENTRY_W - 2]);
            head_addr[r]  = pkt_head[r*ENTRY_W + `XLEN +: `XLEN];
            head_wdata[r] = pkt_head[r*ENTRY_W +: `XLEN];
        end
    end

    // Rows of the head packet still waiting for memory
    assign pending = fifo_valid ? (head_valid & ~completed) : '0;

    // Lowest pending row wins
    always_comb begin
        next_row   = '0;
        next_found = 1'b0;
        for (int r = `GRID_ROWS - 1; r >= 0; r--) begin
            if (pending[r]) begin
                next_row   = ROW_W'(r);
                next_found = 1'b1;
            end
        end
    end

    assign row_onehot = `GRID_ROWS'(1) << next_row;

    assign lsq_req   = next_found;
    assign lsq_op    = head_op[next_row];
    assign lsq_addr  = head_addr[next_row];
    assign lsq_wdata = head_wdata[next_row];

    // Head leaves once its last pending row is served
    assign pop = lsq_done && ((pending & ~row_onehot) == '0);

    // Host stays out while packets are queued or the grid runs
    assign lsq_lock = fifo_valid || rca_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            completed <= '0;
        end else if (pop) begin
            completed <= '0;
        end else if (lsq_done) begin
            completed <= completed | row_onehot;
        end
    end

    // One access in flight, so a single destination register suffices
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_pending <= 1'b0;
            load_row     <= '0;
        end else begin
            load_pending <= lsq_done && (lsq_op == rca_pkg::OP_LOAD);
            if (lsq_done) begin
                load_row <= next_row;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lsq_done) begin
            load_data <= lsq_rdata;
        end
    end

    assign row_load_done = load_pending ? (`GRID_ROWS'(1) << load_row) : '0;

    always_comb begin
        for (int r = 0; r < `GRID_ROWS; r++) begin
            row_load_data[r] = (load_row == ROW_W'(r)) ? load_data : '0;
        end
    end

endmodule

// File: rca_mem_checker.sv
`timescale 1ns/1ps
`include "rca_consts.svh"

module rca_mem_checker (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         exp_push,
    input  logic [127:0]                 exp_name,
    input  logic                         exp_host,
    input  logic [`GRID_ROWS-1:0]        exp_mask,
    input  logic [`GRID_ROWS*`XLEN-1:0]  exp_data,
    input  logic [`GRID_ROWS-1:0]        row_load_done,
    input  logic [`XLEN-1:0]             row_load_data [`GRID_ROWS],
    input  logic                         host_done,
    input  logic [`XLEN-1:0]             host_rdata,
    input  logic                         rca_busy,
    input  logic                         lsq_full,
    input  logic                         final_check,
    output logic                         idle,
    output int                           pass_count,
    output int                           fail_count
);
    // Tests in completion order; grid packets and host accesses finish in order
    logic [127:0]                name_q [$];
    bit                          host_q [$];
    logic [`GRID_ROWS-1:0]       mask_q [$];
    logic [`GRID_ROWS*`XLEN-1:0] data_q [$];
    bit                          bad_q [$];
    bit                          full_seen;

    initial begin
        idle       = 1'b1;
        pass_count = 0;
        fail_count = 0;
        full_seen  = 1'b0;
    end

    function automatic int lowest_row(input logic [`GRID_ROWS-1:0] m);
        int found;
        found = -1;
        for (int r = `GRID_ROWS - 1; r >= 0; r--) begin
            if (m[r]) found = r;
        end
        return found;
    endfunction

    task automatic finish_head();
        if (bad_q[0]) begin
            fail_count++;
            $display("Test %0s failed", name_q[0]);
        end else begin
            pass_count++;
            $display("Test %0s passed", name_q[0]);
        end
        void'(name_q.pop_front());
        void'(host_q.pop_front());
        void'(mask_q.pop_front());
        void'(data_q.pop_front());
        void'(bad_q.pop_front());
    endtask

    task automatic check_load();
        int                    r;
        logic [`GRID_ROWS-1:0] want;
        logic [`XLEN-1:0]      exp_word;
        if (name_q.size() == 0 || host_q[0]) begin
            $display("Load result on rows %b arrived with no grid test waiting", row_load_done);
            fail_count++;
        end else begin
            r = lowest_row(mask_q[0]);
            want = `GRID_ROWS'(1) << r;
            exp_word = data_q[0][r*`XLEN +: `XLEN];
            if (row_load_done != want) begin
                $display("Fail %0s: rows expected %b actual %b", name_q[0], want, row_load_done);
                bad_q[0] = 1'b1;
            end else if (row_load_data[r] != exp_word) begin
                $display("Fail %0s: row %0d expected %h actual %h",
                         name_q[0], r, exp_word, row_load_data[r]);
                bad_q[0] = 1'b1;
            end
            mask_q[0] = mask_q[0] & ~want;
        end
    endtask

    task automatic check_host();
        logic [`GRID_ROWS-1:0] m;
        if (rca_busy) begin
            $display("Host access completed while the grid was busy");
            fail_count++;
        end
        if (name_q.size() == 0 || !host_q[0]) begin
            $display("Host access completed with no host test waiting");
            fail_count++;
        end else begin
            m = mask_q[0];
            if (m[0] && host_rdata != data_q[0][`XLEN-1:0]) begin
                $display("Fail %0s: expected %h actual %h",
                         name_q[0], data_q[0][`XLEN-1:0], host_rdata);
                bad_q[0] = 1'b1;
            end
            finish_head();
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (exp_push) begin
                name_q.push_back(exp_name);
                host_q.push_back(exp_host);
                mask_q.push_back(exp_mask);
                data_q.push_back(exp_data);
                bad_q.push_back(1'b0);
            end
            if (row_load_done != '0) check_load();
            if (host_done) check_host();
            // Grid tests end once every load row has reported
            while (name_q.size() > 0 && !host_q[0] && mask_q[0] == '0) begin
                finish_head();
            end
            if (lsq_full) full_seen = 1'b1;
            if (final_check && !full_seen) begin
                $display("The load/store queue never reported full during the run");
                fail_count++;
            end
        end
        idle = (name_q.size() == 0);
    end

endmodule

// File: rca_mem_props.sv
`timescale 1ns/1ps
`include "rca_consts.svh"

module rca_mem_props (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  psel,
    input logic                  penable,
    input logic [`XLEN-1:0]      paddr,
    input logic                  host_done,
    input logic                  lsq_lock,
    input logic                  lsq_done,
    input logic [`GRID_ROWS-1:0] row_load_done
);
    // Access phase follows exactly one setup cycle
    penable_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> psel && $past(psel) && !$past(penable))
        else $error("penable rose without a preceding setup cycle");

    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        psel && $past(psel) |-> $stable(paddr))
        else $error("paddr changed during an APB transfer");

    host_locked_out: assert property (@(posedge clk) disable iff (!rst_n)
        lsq_lock |-> !host_done)
        else $error("host access completed while the LSQ held the lock");

    // A load result names one row and follows the completing LSQ access
    load_done_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        row_load_done != '0 |-> $onehot(row_load_done) && $past(lsq_done))
        else $error("row_load_done was not a single row following lsq_done");

endmodule

bind rca_mem_subsys rca_mem_props u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .psel          (psel),
    .penable       (penable),
    .paddr         (paddr),
    .host_done     (host_done),
    .lsq_lock      (lsq_lock),
    .lsq_done      (lsq_done),
    .row_load_done (row_load_done)
);

// File: rca_mem_subsys.sv
`timescale 1ns/1ps
`include "rca_consts.svh"

module rca_mem_subsys (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`GRID_ROWS-1:0] row_valid,
    input  rca_pkg::mem_op_e      row_op [`GRID_ROWS],
    input  logic [`XLEN-1:0]      row_addr [`GRID_ROWS],
    input  logic [`XLEN-1:0]      row_wdata [`GRID_ROWS],
    input  logic                  rca_busy,
    output logic                  lsq_full,
    output logic [`GRID_ROWS-1:0] row_load_done,
    output logic [`XLEN-1:0]      row_load_data [`GRID_ROWS],
    input  logic                  host_req,
    input  rca_pkg::mem_op_e      host_op,
    input  logic [`XLEN-1:0]      host_addr,
    input  logic [`XLEN-1:0]      host_wdata,
    output logic                  host_done,
    output logic [`XLEN-1:0]      host_rdata
);
    // LSQ side of the arbiter
    logic             lsq_req;
    rca_pkg::mem_op_e lsq_op;
    logic [`XLEN-1:0] lsq_addr;
    logic [`XLEN-1:0] lsq_wdata;
    logic             lsq_lock;
    logic             lsq_done;
    logic [`XLEN-1:0] lsq_rdata;

    // APB
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [`XLEN-1:0] paddr;
    logic [`XLEN-1:0] pwdata;
    logic [`XLEN-1:0] prdata;
    logic             pready;

    rca_lsq u_lsq (
        .clk           (clk),
        .rst_n         (rst_n),
        .row_valid     (row_valid),
        .row_op        (row_op),
        .row_addr      (row_addr),
        .row_wdata     (row_wdata),
        .rca_busy      (rca_busy),
        .lsq_full      (lsq_full),
        .row_load_done (row_load_done),
        .row_load_data (row_load_data),
        .lsq_req       (lsq_req),
        .lsq_op        (lsq_op),
        .lsq_addr      (lsq_addr),
        .lsq_wdata     (lsq_wdata),
        .lsq_lock      (lsq_lock),
        .lsq_done      (lsq_done),
        .lsq_rdata     (lsq_rdata)
    );

    mem_arbiter u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_req   (host_req),
        .host_op    (host_op),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_done  (host_done),
        .host_rdata (host_rdata),
        .lsq_req    (lsq_req),
        .lsq_op     (lsq_op),
        .lsq_addr   (lsq_addr),
        .lsq_wdata  (lsq_wdata),
        .lsq_lock   (lsq_lock),
        .lsq_done   (lsq_done),
        .lsq_rdata  (lsq_rdata),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready)
    );

    apb_data_mem u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

endmodule

// File: rca_pkg.sv
package rca_pkg;

    // Memory opcode of a grid row or host request
    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_e;

    // APB phase of the memory arbiter
    typedef enum logic [1:0] {
        ARB_IDLE   = 2'd0,
        ARB_SETUP  = 2'd1,
        ARB_ACCESS = 2'd2
    } arb_state_e;

endpackage

// File: rca_testdata.txt
# name kind(G grid, H host) gap busy valid opmask(1=store) then addr/data per row 0..3
# then expected load value per row 0..3 (host uses row 0 fields only)
host_st0 H 1 0 1 1 10 1111 00 0 00 0 00 0 0 0 0 0
host_st1 H 1 0 1 1 14 2222 00 0 00 0 00 0 0 0 0 0
host_ld0 H 1 0 1 0 10 0 00 0 00 0 00 0 1111 0 0 0
host_ld1 H 1 0 1 0 14 0 00 0 00 0 00 0 2222 0 0 0
grid_st G 1 0 f f 20 a001 24 a002 28 a003 2c a004 0 0 0 0
grid_ld G 1 0 f 0 20 0 24 0 28 0 2c 0 a001 a002 a003 a004
grid_mix G 1 0 f 5 30 b000 10 0 34 b002 14 0 0 1111 0 2222
grid_sparse G 1 0 a 0 00 0 24 0 00 0 2c 0 0 a002 0 a004
grid_busy G 0 0 f f 40 c000 44 c001 48 c002 4c c003 0 0 0 0
host_busy H 1 12 1 0 48 0 00 0 00 0 00 0 c002 0 0 0
burst0 G 0 0 f f 50 d000 54 d001 58 d002 5c d003 0 0 0 0
burst1 G 0 0 f 0 50 0 54 0 58 0 5c 0 d000 d001 d002 d003
burst2 G 0 0 f f 60 e000 64 e001 68 e002 6c e003 0 0 0 0
burst3 G 0 0 f 0 60 0 64 0 68 0 6c 0 e000 e001 e002 e003
burst4 G 0 0 5 0 54 0 00 0 6c 0 00 0 d001 0 e003 0
burst5 G 1 0 9 0 58 0 00 0 00 0 64 0 d002 0 0 e001
host_fin H 1 0 1 0 6c 0 00 0 00 0 00 0 e003 0 0 0

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_rca_mem -o sim_rca_mem
./obj_dir/sim_rca_mem | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// File: sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out,
    output logic             valid,
    output logic             full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign do_push  = push && !full;
    assign do_pop   = pop && valid;
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap explicitly so DEPTH need not be a power of two
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

endmodule

// File: tb_rca_mem.sv
`timescale 1ns/1ps
`include "rca_consts.svh"

module tb_rca_mem;
    localparam int MAX_TESTS       = 32;
    localparam int CYCLES_PER_TEST = 200;
    // Longest queue drain, four cycles per access
    localparam int DRAIN_CYCLES    = `PKT_DEPTH * `GRID_ROWS * 4;

    logic                  clk;
    logic                  rst_n;
    logic [`GRID_ROWS-1:0] row_valid;
    rca_pkg::mem_op_e      row_op [`GRID_ROWS];
    logic [`XLEN-1:0]      row_addr [`GRID_ROWS];
    logic [`XLEN-1:0]      row_wdata [`GRID_ROWS];
    logic                  rca_busy;
    logic                  lsq_full;
    logic [`GRID_ROWS-1:0] row_load_done;
    logic [`XLEN-1:0]      row_load_data [`GRID_ROWS];
    logic                  host_req;
    rca_pkg::mem_op_e      host_op;
    logic [`XLEN-1:0]      host_addr;
    logic [`XLEN-1:0]      host_wdata;
    logic                  host_done;
    logic [`XLEN-1:0]      host_rdata;

    logic                        exp_push;
    logic [127:0]                exp_name;
    logic                        exp_host;
    logic [`GRID_ROWS-1:0]       exp_mask;
    logic [`GRID_ROWS*`XLEN-1:0] exp_data;
    logic                        final_check;
    logic                        idle;
    int                          pass_count;
    int                          fail_count;

    // Test table from the data file
    logic [127:0]          t_name [MAX_TESTS];
    logic [7:0]            t_kind [MAX_TESTS];
    int                    t_gap [MAX_TESTS];
    int                    t_busy [MAX_TESTS];
    logic [`GRID_ROWS-1:0] t_valid [MAX_TESTS];
    logic [`GRID_ROWS-1:0] t_op [MAX_TESTS];
    logic [`XLEN-1:0]      t_addr [MAX_TESTS][`GRID_ROWS];
    logic [`XLEN-1:0]      t_data [MAX_TESTS][`GRID_ROWS];
    logic [`XLEN-1:0]      t_exp [MAX_TESTS][`GRID_ROWS];
    int                    n_tests;
    bit                    file_ok;
    int                    cycles;
    int                    cycle_limit;

    rca_mem_subsys dut (.*);

    rca_mem_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic load_tests();
        int    fd;
        int    cnt;
        string line;
        fd = $fopen("rca_testdata.txt", "r");
        file_ok = (fd != 0);
        if (file_ok) begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    cnt = $sscanf(line, "%s %s %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        t_name[n_tests], t_kind[n_tests], t_gap[n_tests], t_busy[n_tests],
                        t_valid[n_tests], t_op[n_tests],
                        t_addr[n_tests][0], t_data[n_tests][0],
                        t_addr[n_tests][1], t_data[n_tests][1],
                        t_addr[n_tests][2], t_data[n_tests][2],
                        t_addr[n_tests][3], t_data[n_tests][3],
                        t_exp[n_tests][0], t_exp[n_tests][1],
                        t_exp[n_tests][2], t_exp[n_tests][3]);
                    if (cnt == 18) n_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Offer one packet, held off while the queue is full
    task automatic submit_packet(input int i);
        while (lsq_full) @(negedge clk);
        row_valid = t_valid[i];
        for (int r = 0; r < `GRID_ROWS; r++) begin
            row_op[r]    = t_op[i][r] ? rca_pkg::OP_STORE : rca_pkg::OP_LOAD;
            row_addr[r]  = t_addr[i][r];
            row_wdata[r] = t_data[i][r];
            exp_data[r*`XLEN +: `XLEN] = t_exp[i][r];
        end
        exp_name = t_name[i];
        exp_host = 1'b0;
        exp_mask = t_valid[i] & ~t_op[i];
        exp_push = 1'b1;
        @(negedge clk);
        row_valid = '0;
        exp_push  = 1'b0;
    endtask

    // Host access; a busy grid outlasts the queue drain by t_busy cycles
    task automatic host_access(input int i);
        int waited;
        int busy_len;
        busy_len   = (t_busy[i] > 0) ? DRAIN_CYCLES + t_busy[i] : 0;
        rca_busy   = (busy_len > 0);
        host_req   = 1'b1;
        host_op    = t_op[i][0] ? rca_pkg::OP_STORE : rca_pkg::OP_LOAD;
        host_addr  = t_addr[i][0];
        host_wdata = t_data[i][0];
        exp_name   = t_name[i];
        exp_host   = 1'b1;
        exp_mask   = {{(`GRID_ROWS-1){1'b0}}, !t_op[i][0]};
        exp_data   = '0;
        exp_data[`XLEN-1:0] = t_exp[i][0];
        exp_push   = 1'b1;
        @(negedge clk);
        exp_push = 1'b0;
        waited   = 1;
        while (!host_done) begin
            if (waited >= busy_len) rca_busy = 1'b0;
            @(negedge clk);
            waited++;
        end
        host_req = 1'b0;
        rca_busy = 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (!idle) @(negedge clk);
    endtask

    initial begin
        rst_n       = 1'b0;
        row_valid   = '0;
        rca_busy    = 1'b0;
        host_req    = 1'b0;
        host_op     = rca_pkg::OP_LOAD;
        host_addr   = '0;
        host_wdata  = '0;
        exp_push    = 1'b0;
        exp_name    = '0;
        exp_host    = 1'b0;
        exp_mask    = '0;
        exp_data    = '0;
        final_check = 1'b0;
        for (int r = 0; r < `GRID_ROWS; r++) begin
            row_op[r]    = rca_pkg::OP_LOAD;
            row_addr[r]  = '0;
            row_wdata[r] = '0;
        end
        n_tests     = 0;
        cycles      = 0;
        cycle_limit = 0;
        void'($urandom(45838));
        load_tests();
        if (!file_ok || n_tests == 0) begin
            $display("Could not read any test from rca_testdata.txt");
            $display("Something failed");
            $finish;
        end else begin
            cycle_limit = n_tests * CYCLES_PER_TEST;
            repeat (5) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            for (int i = 0; i < n_tests; i++) begin
                if (t_kind[i] == "H") host_access(i);
                else submit_packet(i);
                // Gap zero keeps the next test back to back with this one
                if (t_gap[i] > 0) begin
                    wait_idle();
                    repeat (t_gap[i] + int'($urandom % 4)) @(negedge clk);
                end
            end
            wait_idle();
            final_check = 1'b1;
            @(negedge clk);
            final_check = 1'b0;
            @(negedge clk);
            $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule
